// File: verilog.f
mini_cpu_pkg.sv
pipeline_control.sv
fetch_cache.sv
decode_issue.sv
exec_units.sv
reorder_buffer.sv
mini_cpu.sv
mini_cpu_asserts.sv
tb_memory_model.sv
tb_mini_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mini_cpu
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All checks passed

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb_mini_cpu.sv
module tb_mini_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int retire_target   = 200;
    localparam int watchdog_cycles = retire_target * 40;

    logic                                                    clk, reset;
    logic                                                    mem_req, mem_ready;
    logic [mini_cpu_pkg::block_bits-1:0]                     mem_addr;
    logic [mini_cpu_pkg::block_words*mini_cpu_pkg::xlen-1:0] mem_rdata;
    logic                                                    retire_valid, retire_we;
    logic                                                    retire_excep;
    logic [mini_cpu_pkg::xlen-1:0]                           retire_pc, retire_value;
    logic [mini_cpu_pkg::reg_bits-1:0]                       retire_rd;

    logic [mini_cpu_pkg::xlen-1:0] model_regs [mini_cpu_pkg::reg_count];
    logic [mini_cpu_pkg::xlen-1:0] expect_pc;
    int                            retired, pc_errors, value_errors;

    mini_cpu i_mini_cpu (.*);

    tb_memory_model i_memory_model (
        .clk(clk), .reset(reset), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_rdata(mem_rdata), .mem_ready(mem_ready)
    );

    // sequential interpreter step on the model register file
    function automatic logic [15:0] reference_result(input mini_cpu_pkg::instr_t ins);
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] imm;
        a   = model_regs[ins.r.rs1];
        b   = model_regs[ins.r.rs2];
        imm = {{7{ins.i.imm[8]}}, ins.i.imm};
        case (ins.r.opcode)
            mini_cpu_pkg::op_add:  return a + b;
            mini_cpu_pkg::op_sub:  return a - b;
            mini_cpu_pkg::op_and:  return a & b;
            mini_cpu_pkg::op_xor:  return a ^ b;
            mini_cpu_pkg::op_mul:  return a * b;
            mini_cpu_pkg::op_addi: return model_regs[ins.i.rd] + imm;
            mini_cpu_pkg::op_li:   return imm;
            default:               return '0;
        endcase
    endfunction

    task automatic print_counts();
        $display("retired %0d, pc errors %0d, value errors %0d",
                 retired, pc_errors, value_errors);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ============================================================
    // retire checker
    // ============================================================
    always @(negedge clk) begin : compare_retire
        mini_cpu_pkg::instr_t ins;
        logic [15:0]          exp_value;
        logic                 exp_excep;
        if (!reset && retire_valid && retired < retire_target) begin
            ins       = i_memory_model.words[expect_pc[7:0]];
            exp_excep = (ins.r.opcode > mini_cpu_pkg::op_li);
            if (retire_pc !== expect_pc) begin
                $display("Fail %0t retire_pc expected %h actual %h", $time, expect_pc, retire_pc);
                pc_errors++;
            end
            if (retire_excep !== exp_excep) begin
                $display("Fail %0t retire_excep expected %b actual %b",
                         $time, exp_excep, retire_excep);
                value_errors++;
            end
            if (exp_excep) begin
                if (retire_we !== 1'b0) begin
                    $display("Fail %0t retire_we expected 0 actual %b", $time, retire_we);
                    value_errors++;
                end
            end else begin
                exp_value = reference_result(ins);
                if (retire_we !== 1'b1) begin
                    $display("Fail %0t retire_we expected 1 actual %b", $time, retire_we);
                    value_errors++;
                end
                if (retire_rd !== ins.r.rd) begin
                    $display("Fail %0t retire_rd expected %0d actual %0d",
                             $time, ins.r.rd, retire_rd);
                    value_errors++;
                end
                if (retire_value !== exp_value) begin
                    $display("Fail %0t retire_value expected %h actual %h",
                             $time, exp_value, retire_value);
                    value_errors++;
                end
                model_regs[ins.r.rd] = exp_value;
            end
            expect_pc = expect_pc + 1'b1;
            retired++;
        end
    end

    initial begin
        reset        = 1'b1;
        expect_pc    = '0;
        retired      = 0;
        pc_errors    = 0;
        value_errors = 0;
        for (int i = 0; i < mini_cpu_pkg::reg_count; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait (retired == retire_target);
        @(negedge clk);
        print_counts();
        if (pc_errors == 0 && value_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Retirement stalled: only %0d of %0d instructions retired before the watchdog",
                 retired, retire_target);
        print_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

// File: tb_memory_model.sv
module tb_memory_model (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    mem_req,
    input  logic [mini_cpu_pkg::block_bits-1:0]                     mem_addr,
    output logic [mini_cpu_pkg::block_words*mini_cpu_pkg::xlen-1:0] mem_rdata,
    output logic                                                    mem_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [mini_cpu_pkg::xlen-1:0] words [256];
    int                            seed = 25;
    int                            delay;
    logic                          active;

    // random program with one word in eight illegal and mul weighted up
    initial begin
        int          pick;
        logic [15:0] word;
        mem_ready = 1'b0;
        mem_rdata = '0;
        active    = 1'b0;
        delay     = 0;
        for (int i = 0; i < 256; i++) begin
            word = 16'($random(seed));
            pick = {$random(seed)} % 16;
            if (pick < 2) begin
                word[15:12] = 4'(7 + {$random(seed)} % 9);
            end else if (pick < 6) begin
                word[15:12] = mini_cpu_pkg::op_mul;
            end else if (pick < 8) begin
                word[15:12] = mini_cpu_pkg::op_li;
            end else begin
                word[15:12] = 4'({$random(seed)} % 7);
            end
            words[i] = word;
        end
    end

    // one ready pulse per request after 1 to 6 cycles
    always @(negedge clk) begin
        if (reset || mem_ready || !mem_req) begin
            mem_ready = 1'b0;
            active    = 1'b0;
        end else if (!active) begin
            active = 1'b1;
            delay  = 1 + {$random(seed)} % 6;
        end else begin
            delay = delay - 1;
            if (delay == 0) begin
                mem_ready = 1'b1;
                mem_rdata = {words[{mem_addr[5:0], 2'd3}], words[{mem_addr[5:0], 2'd2}],
                             words[{mem_addr[5:0], 2'd1}], words[{mem_addr[5:0], 2'd0}]};
            end
        end
    end

endmodule

// File: mini_cpu_asserts.sv
module mini_cpu_asserts (
    input logic                                clk,
    input logic                                reset,
    input logic                                mem_req,
    input logic [mini_cpu_pkg::block_bits-1:0] mem_addr,
    input logic                                mem_ready,
    input logic                                retire_valid,
    input logic                                retire_we,
    input logic                                retire_excep
);
    timeunit 1ns;
    timeprecision 1ps;

    // block address held until the memory answers
    mem_addr_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr))
        else $error("mem_addr or mem_req changed before mem_ready");

    excep_no_write: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !(retire_we && retire_excep))
        else $error("retire_we high together with retire_excep");

    // quiet for four cycles once reset drops
    quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
        retire_valid |-> !$past(reset, 1) && !$past(reset, 2) && !$past(reset, 3)
                         && !$past(reset, 4))
        else $error("retire_valid too soon after reset release");

endmodule

bind mini_cpu mini_cpu_asserts i_mini_cpu_asserts (
    .clk(clk), .reset(reset), .mem_req(mem_req), .mem_addr(mem_addr),
    .mem_ready(mem_ready), .retire_valid(retire_valid), .retire_we(retire_we),
    .retire_excep(retire_excep)
);

// File: mini_cpu.sv
module mini_cpu (
    input  logic                                                     clk,
    input  logic                                                     reset,
    output logic                                                     mem_req,
    output logic [mini_cpu_pkg::block_bits-1:0]                      mem_addr,
    input  logic [mini_cpu_pkg::block_words*mini_cpu_pkg::xlen-1:0]  mem_rdata,
    input  logic                                                     mem_ready,
    output logic                                                     retire_valid,
    output logic [mini_cpu_pkg::xlen-1:0]                            retire_pc,
    output logic [mini_cpu_pkg::reg_bits-1:0]                        retire_rd,
    output logic                                                     retire_we,
    output logic [mini_cpu_pkg::xlen-1:0]                            retire_value,
    output logic                                                     retire_excep
);

    // ============================================================
    // control and fetch
    // ============================================================
    logic                              freeze_front, flush, rob_full;
    logic [mini_cpu_pkg::xlen-1:0]     redirect_pc;
    logic                              fetch_req, fetch_valid;
    logic [mini_cpu_pkg::xlen-1:0]     fetch_pc, fetch_instr;

    // ============================================================
    // dispatch and completion
    // ============================================================
    logic                              alloc_valid, alloc_we, alloc_excep, issue_valid;
    logic [mini_cpu_pkg::xlen-1:0]     alloc_pc, issue_a, issue_b, alu_value, mul_value;
    logic [mini_cpu_pkg::reg_bits-1:0] alloc_rd;
    logic [mini_cpu_pkg::tag_bits-1:0] alloc_tag, issue_tag, alu_tag, mul_tag;
    logic [3:0]                        issue_op;
    logic                              alu_done, mul_done;

    pipeline_control u_pipeline_control (
        .clk(clk), .reset(reset), .rob_full(rob_full), .retire_valid(retire_valid),
        .retire_excep(retire_excep), .retire_pc(retire_pc),
        .freeze_front(freeze_front), .flush(flush), .redirect_pc(redirect_pc)
    );

    fetch_cache u_fetch_cache (
        .clk(clk), .reset(reset), .flush(flush), .fetch_req(fetch_req), .fetch_pc(fetch_pc),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata), .fetch_valid(fetch_valid),
        .fetch_instr(fetch_instr), .mem_req(mem_req), .mem_addr(mem_addr)
    );

    decode_issue u_decode_issue (
        .clk(clk), .reset(reset), .freeze_front(freeze_front), .flush(flush),
        .redirect_pc(redirect_pc), .fetch_valid(fetch_valid), .fetch_instr(fetch_instr),
        .alloc_tag(alloc_tag), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_we(retire_we), .retire_value(retire_value),
        .fetch_req(fetch_req), .fetch_pc(fetch_pc), .alloc_valid(alloc_valid),
        .alloc_pc(alloc_pc), .alloc_rd(alloc_rd), .alloc_we(alloc_we), .alloc_excep(alloc_excep),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b),
        .issue_tag(issue_tag)
    );

    exec_units u_exec_units (
        .clk(clk), .reset(reset), .flush(flush), .issue_valid(issue_valid),
        .issue_op(issue_op), .issue_a(issue_a), .issue_b(issue_b), .issue_tag(issue_tag),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_value(alu_value),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_value(mul_value)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk), .reset(reset), .flush(flush), .alloc_valid(alloc_valid),
        .alloc_pc(alloc_pc), .alloc_rd(alloc_rd), .alloc_we(alloc_we), .alloc_excep(alloc_excep),
        .alu_done(alu_done), .alu_tag(alu_tag), .alu_value(alu_value),
        .mul_done(mul_done), .mul_tag(mul_tag), .mul_value(mul_value),
        .alloc_tag(alloc_tag), .rob_full(rob_full), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .retire_rd(retire_rd), .retire_we(retire_we),
        .retire_value(retire_value), .retire_excep(retire_excep)
    );

endmodule

// File: reorder_buffer.sv
module reorder_buffer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic                              alloc_valid,
    input  logic [mini_cpu_pkg::xlen-1:0]     alloc_pc,
    input  logic [mini_cpu_pkg::reg_bits-1:0] alloc_rd,
    input  logic                              alloc_we,
    input  logic                              alloc_excep,
    input  logic                              alu_done,
    input  logic [mini_cpu_pkg::tag_bits-1:0] alu_tag,
    input  logic [mini_cpu_pkg::xlen-1:0]     alu_value,
    input  logic                              mul_done,
    input  logic [mini_cpu_pkg::tag_bits-1:0] mul_tag,
    input  logic [mini_cpu_pkg::xlen-1:0]     mul_value,
    output logic [mini_cpu_pkg::tag_bits-1:0] alloc_tag,
    output logic                              rob_full,
    output logic                              retire_valid,
    output logic [mini_cpu_pkg::xlen-1:0]     retire_pc,
    output logic [mini_cpu_pkg::reg_bits-1:0] retire_rd,
    output logic                              retire_we,
    output logic [mini_cpu_pkg::xlen-1:0]     retire_value,
    output logic                              retire_excep
);

    logic [mini_cpu_pkg::xlen-1:0]      pc_q    [mini_cpu_pkg::rob_depth];
    logic [mini_cpu_pkg::reg_bits-1:0]  rd_q    [mini_cpu_pkg::rob_depth];
    logic [mini_cpu_pkg::xlen-1:0]      value_q [mini_cpu_pkg::rob_depth];
    logic [mini_cpu_pkg::rob_depth-1:0] we_q, done_q, excep_q;
    logic [mini_cpu_pkg::tag_bits-1:0]  head, tail;
    logic [mini_cpu_pkg::tag_bits:0]    count;
    logic                               do_retire;

    // head leaves once its done bit is visible but never during a flush
    assign do_retire = (count != '0) && done_q[head] && !flush;

    assign alloc_tag    = tail;
    assign rob_full     = (count == mini_cpu_pkg::rob_depth);
    assign retire_valid = do_retire;
    assign retire_pc    = pc_q[head];
    assign retire_rd    = rd_q[head];
    assign retire_we    = we_q[head];
    assign retire_value = value_q[head];
    assign retire_excep = excep_q[head];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_valid) begin
                tail <= tail + 1'b1;
            end
            if (do_retire) begin
                head <= head + 1'b1;
            end
            count <= count + {{mini_cpu_pkg::tag_bits{1'b0}}, alloc_valid}
                           - {{mini_cpu_pkg::tag_bits{1'b0}}, do_retire};
        end
    end

    // ============================================================
    // entry writes from allocation and the two completion ports
    // ============================================================
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            pc_q[tail]    <= alloc_pc;
            rd_q[tail]    <= alloc_rd;
            we_q[tail]    <= alloc_we;
            value_q[tail] <= '0;
            // illegal words arrive already complete
            done_q[tail]  <= alloc_excep;
            excep_q[tail] <= alloc_excep;
        end
        if (alu_done) begin
            done_q[alu_tag]  <= 1'b1;
            value_q[alu_tag] <= alu_value;
        end
        if (mul_done) begin
            done_q[mul_tag]  <= 1'b1;
            value_q[mul_tag] <= mul_value;
        end
    end

endmodule

// File: exec_units.sv
module exec_units (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic                              issue_valid,
    input  logic [3:0]                        issue_op,
    input  logic [mini_cpu_pkg::xlen-1:0]     issue_a,
    input  logic [mini_cpu_pkg::xlen-1:0]     issue_b,
    input  logic [mini_cpu_pkg::tag_bits-1:0] issue_tag,
    output logic                              alu_done,
    output logic [mini_cpu_pkg::tag_bits-1:0] alu_tag,
    output logic [mini_cpu_pkg::xlen-1:0]     alu_value,
    output logic                              mul_done,
    output logic [mini_cpu_pkg::tag_bits-1:0] mul_tag,
    output logic [mini_cpu_pkg::xlen-1:0]     mul_value
);

    logic                              is_mul;
    logic [mini_cpu_pkg::xlen-1:0]     alu_result;
    logic [2:0]                        mul_v;
    logic [mini_cpu_pkg::tag_bits-1:0] mul_t [3];
    logic [mini_cpu_pkg::xlen-1:0]     pp_lo, prod;
    logic [7:0]                        pp_hi;

    assign is_mul = (issue_op == mini_cpu_pkg::op_mul);

    always_comb begin
        case (issue_op)
            mini_cpu_pkg::op_add:  alu_result = issue_a + issue_b;
            mini_cpu_pkg::op_sub:  alu_result = issue_a - issue_b;
            mini_cpu_pkg::op_and:  alu_result = issue_a & issue_b;
            mini_cpu_pkg::op_xor:  alu_result = issue_a ^ issue_b;
            mini_cpu_pkg::op_addi: alu_result = issue_a + issue_b;
            mini_cpu_pkg::op_li:   alu_result = issue_b;
            default:               alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            alu_done <= 1'b0;
            mul_v    <= '0;
        end else begin
            alu_done <= issue_valid && !is_mul;
            mul_v    <= {mul_v[1:0], issue_valid && is_mul};
        end
    end

    // ============================================================
    // three stage multiplier keeping the low 16 bits
    // ============================================================
    always_ff @(posedge clk) begin
        alu_tag   <= issue_tag;
        alu_value <= alu_result;
        mul_t[0]  <= issue_tag;
        mul_t[1]  <= mul_t[0];
        mul_t[2]  <= mul_t[1];
        pp_lo     <= issue_a * issue_b[7:0];
        pp_hi     <= issue_a[7:0] * issue_b[15:8];
        prod      <= pp_lo + {pp_hi, 8'b0};
        mul_value <= prod;
    end

    assign mul_done = mul_v[2];
    assign mul_tag  = mul_t[2];

endmodule

// File: decode_issue.sv
module decode_issue (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              freeze_front,
    input  logic                              flush,
    input  logic [mini_cpu_pkg::xlen-1:0]     redirect_pc,
    input  logic                              fetch_valid,
    input  logic [mini_cpu_pkg::xlen-1:0]     fetch_instr,
    input  logic [mini_cpu_pkg::tag_bits-1:0] alloc_tag,
    input  logic                              retire_valid,
    input  logic [mini_cpu_pkg::reg_bits-1:0] retire_rd,
    input  logic                              retire_we,
    input  logic [mini_cpu_pkg::xlen-1:0]     retire_value,
    output logic                              fetch_req,
    output logic [mini_cpu_pkg::xlen-1:0]     fetch_pc,
    output logic                              alloc_valid,
    output logic [mini_cpu_pkg::xlen-1:0]     alloc_pc,
    output logic [mini_cpu_pkg::reg_bits-1:0] alloc_rd,
    output logic                              alloc_we,
    output logic                              alloc_excep,
    output logic                              issue_valid,
    output logic [3:0]                        issue_op,
    output logic [mini_cpu_pkg::xlen-1:0]     issue_a,
    output logic [mini_cpu_pkg::xlen-1:0]     issue_b,
    output logic [mini_cpu_pkg::tag_bits-1:0] issue_tag
);

    logic [mini_cpu_pkg::xlen-1:0]      pc, hold_pc;
    logic                               fetch_pending, hold_valid;
    mini_cpu_pkg::instr_t               hold_instr;
    logic [mini_cpu_pkg::xlen-1:0]      regs [mini_cpu_pkg::reg_count];
    logic [mini_cpu_pkg::reg_count-1:0] busy;
    logic [3:0]                         opcode;
    logic [mini_cpu_pkg::reg_bits-1:0]  rd, src_a, src_b;
    logic                               illegal, is_imm, use_a, use_b;
    logic                               blocked, do_issue, want_fetch;

    // ============================================================
    // decode of the held word
    // ============================================================
    assign opcode  = hold_instr.r.opcode;
    assign rd      = hold_instr.r.rd;
    assign illegal = (opcode > mini_cpu_pkg::op_li);
    assign is_imm  = (opcode == mini_cpu_pkg::op_addi) || (opcode == mini_cpu_pkg::op_li);
    // addi reads its own destination
    assign src_a   = is_imm ? rd : hold_instr.r.rs1;
    assign src_b   = hold_instr.r.rs2;
    assign use_a   = !illegal && (opcode != mini_cpu_pkg::op_li);
    assign use_b   = !illegal && !is_imm;

    // scoreboard check includes the destination
    assign blocked  = (use_a && busy[src_a]) || (use_b && busy[src_b]) || (!illegal && busy[rd]);
    assign do_issue = hold_valid && !freeze_front && !blocked;
    assign want_fetch = !fetch_pending && !freeze_front && (!hold_valid || do_issue);

    assign fetch_pc    = pc;
    assign alloc_valid = do_issue;
    assign alloc_pc    = hold_pc;
    assign alloc_rd    = rd;
    assign alloc_we    = !illegal;
    assign alloc_excep = illegal;
    assign issue_valid = do_issue && !illegal;
    assign issue_op    = opcode;
    assign issue_a     = regs[src_a];
    assign issue_b     = is_imm ? {{(mini_cpu_pkg::xlen-9){hold_instr.i.imm[8]}}, hold_instr.i.imm}
                                : regs[src_b];
    assign issue_tag   = alloc_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc            <= '0;
            fetch_req     <= 1'b0;
            fetch_pending <= 1'b0;
            hold_valid    <= 1'b0;
        end else if (flush) begin
            pc            <= redirect_pc;
            fetch_req     <= 1'b0;
            fetch_pending <= 1'b0;
            hold_valid    <= 1'b0;
        end else begin
            fetch_req <= want_fetch;
            if (want_fetch) begin
                fetch_pending <= 1'b1;
            end else if (fetch_valid) begin
                fetch_pending <= 1'b0;
            end
            if (fetch_valid) begin
                hold_valid <= 1'b1;
                pc         <= pc + 1'b1;
            end else if (do_issue) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            hold_pc    <= pc;
            hold_instr <= fetch_instr;
        end
    end

    // busy bits clear on retire before set on issue
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= '0;
        end else begin
            if (retire_valid && retire_we) begin
                busy[retire_rd] <= 1'b0;
            end
            if (do_issue && !illegal) begin
                busy[rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < mini_cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (retire_valid && retire_we) begin
            regs[retire_rd] <= retire_value;
        end
    end

endmodule

// File: fetch_cache.sv
module fetch_cache (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    flush,
    input  logic                                                    fetch_req,
    input  logic [mini_cpu_pkg::xlen-1:0]                           fetch_pc,
    input  logic                                                    mem_ready,
    input  logic [mini_cpu_pkg::block_words*mini_cpu_pkg::xlen-1:0] mem_rdata,
    output logic                                                    fetch_valid,
    output logic [mini_cpu_pkg::xlen-1:0]                           fetch_instr,
    output logic                                                    mem_req,
    output logic [mini_cpu_pkg::block_bits-1:0]                     mem_addr
);

    logic [mini_cpu_pkg::block_words*mini_cpu_pkg::xlen-1:0] data_q [mini_cpu_pkg::line_count];
    logic [mini_cpu_pkg::cache_tag_bits-1:0] tag_q [mini_cpu_pkg::line_count];
    logic [mini_cpu_pkg::line_count-1:0]     valid_q;
    logic [1:0]                              state;
    logic [mini_cpu_pkg::xlen-1:0]           req_pc;
    logic [mini_cpu_pkg::block_bits-1:0]     fill_block;
    logic [mini_cpu_pkg::index_bits-1:0]     req_index, fill_index;
    logic                                    discard, hit;

    assign req_index  = req_pc[mini_cpu_pkg::offset_bits +: mini_cpu_pkg::index_bits];
    assign fill_index = fill_block[mini_cpu_pkg::index_bits-1:0];
    assign hit = valid_q[req_index] &&
                 (tag_q[req_index] == req_pc[mini_cpu_pkg::xlen-1 -: mini_cpu_pkg::cache_tag_bits]);

    assign fetch_valid = (state == mini_cpu_pkg::st_lookup) && hit && !flush;
    assign fetch_instr = data_q[req_index][mini_cpu_pkg::xlen*req_pc[mini_cpu_pkg::offset_bits-1:0]
                                           +: mini_cpu_pkg::xlen];
    assign mem_req  = (state == mini_cpu_pkg::st_fill);
    assign mem_addr = fill_block;

    // ============================================================
    // idle / lookup / fill
    // ============================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= mini_cpu_pkg::st_idle;
            discard <= 1'b0;
            valid_q <= '0;
        end else begin
            case (state)
                mini_cpu_pkg::st_idle: begin
                    if (fetch_req && !flush) begin
                        req_pc <= fetch_pc;
                        state  <= mini_cpu_pkg::st_lookup;
                    end
                end
                mini_cpu_pkg::st_lookup: begin
                    if (flush || hit) begin
                        state <= mini_cpu_pkg::st_idle;
                    end else begin
                        fill_block <= req_pc[mini_cpu_pkg::xlen-1:mini_cpu_pkg::offset_bits];
                        discard    <= 1'b0;
                        state      <= mini_cpu_pkg::st_fill;
                    end
                end
                mini_cpu_pkg::st_fill: begin
                    // fill always finishes and a flushed request is just forgotten
                    if (flush) begin
                        discard <= 1'b1;
                    end else if (fetch_req) begin
                        discard <= 1'b0;
                        req_pc  <= fetch_pc;
                    end
                    if (mem_ready) begin
                        valid_q[fill_index] <= 1'b1;
                        if (flush || (discard && !fetch_req)) begin
                            state <= mini_cpu_pkg::st_idle;
                        end else begin
                            state <= mini_cpu_pkg::st_lookup;
                        end
                    end
                end
                default: state <= mini_cpu_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == mini_cpu_pkg::st_fill && mem_ready) begin
            data_q[fill_index] <= mem_rdata;
            tag_q[fill_index]  <= fill_block[mini_cpu_pkg::block_bits-1 -: mini_cpu_pkg::cache_tag_bits];
        end
    end

endmodule

// File: pipeline_control.sv
module pipeline_control (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rob_full,
    input  logic                          retire_valid,
    input  logic                          retire_excep,
    input  logic [mini_cpu_pkg::xlen-1:0] retire_pc,
    output logic                          freeze_front,
    output logic                          flush,
    output logic [mini_cpu_pkg::xlen-1:0] redirect_pc
);

    logic excep_retire;

    assign excep_retire = retire_valid && retire_excep;

    // front end waits while the rob is full or about to be cleared
    assign freeze_front = rob_full || excep_retire || flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            flush <= 1'b0;
        end else begin
            flush <= excep_retire;
        end
    end

    // restart after the faulting word
    always_ff @(posedge clk) begin
        if (excep_retire) begin
            redirect_pc <= retire_pc + 1'b1;
        end
    end

endmodule

// File: mini_cpu_pkg.sv
package mini_cpu_pkg;

    // ============================================================
    // machine sizes
    // ============================================================
    localparam int xlen           = 16;
    localparam int reg_count      = 8;
    localparam int reg_bits       = 3;
    localparam int rob_depth      = 8;
    localparam int tag_bits       = 3;
    localparam int block_words    = 4;
    localparam int line_count     = 8;
    localparam int offset_bits    = 2;
    localparam int index_bits     = 3;
    localparam int cache_tag_bits = xlen - offset_bits - index_bits;
    localparam int block_bits     = xlen - offset_bits;

    // opcodes above op_li are illegal
    localparam logic [3:0] op_add  = 4'd0;
    localparam logic [3:0] op_sub  = 4'd1;
    localparam logic [3:0] op_and  = 4'd2;
    localparam logic [3:0] op_xor  = 4'd3;
    localparam logic [3:0] op_mul  = 4'd4;
    localparam logic [3:0] op_addi = 4'd5;
    localparam logic [3:0] op_li   = 4'd6;

    // fetch cache states
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_lookup = 2'd1;
    localparam logic [1:0] st_fill   = 2'd2;

    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [2:0] rd;
            logic [2:0] rs1;
            logic [2:0] rs2;
            logic [2:0] pad;
        } r;
        struct packed {
            logic [3:0] opcode;
            logic [2:0] rd;
            logic [8:0] imm;
        } i;
    } instr_t;

endpackage
